// File: logic/colmix_pkg.sv
/*
 * Colour mixer shared definitions: pixel and layer formats, palette
 * words, colour channels, the CPU handshake states and pipeline constants.
 */
package colmix_pkg;

    // palette geometry
    localparam int PAL_WORDS = 2048;
    localparam int PAL_AW    = $clog2(PAL_WORDS);

    // blanking delay in pxl_cen events, input to output
    localparam int BLANK_DLY = 2;

    // gfx_en bit positions
    localparam int GFX_CHAR = 0;
    localparam int GFX_SCR1 = 1;
    localparam int GFX_SCR2 = 2;
    localparam int GFX_OBJ  = 3;

    // palette word fields
    localparam int PAL_NOSHD = 15; // set: entry ignores shadow
    localparam int PAL_RLSB  = 12;
    localparam int PAL_GLSB  = 13;
    localparam int PAL_BLSB  = 14;

    // char: prio, pal[1:0], colour[3:0]
    typedef logic [6:0] char_pxl_t;

    // scroll: prio, pal[5:0], colour[3:0]
    typedef logic [10:0] scr_pxl_t;

    // sprite: prio[1:0], pal[5:0], colour[3:0]
    typedef logic [11:0] obj_pxl_t;

    // merged candidate: shadow, sprite flag, palette index[9:0]
    typedef logic [11:0] lyr_t;

    typedef logic [PAL_AW-1:0] pal_addr_t;

    // noshd, lsb b/g/r, b[3:0], g[3:0], r[3:0]
    typedef logic [15:0] pal_word_t;

    typedef logic [4:0] color_t;

    typedef logic [14:0] rgb_t; // red, green, blue

    typedef logic [3:0] gfx_en_t;

    // four-phase CPU handshake
    typedef enum logic [1:0] {
        CPU_IDLE,     // waiting for req
        CPU_ACK,      // access done, ack up
        CPU_WAIT_LOW  // req held, keep ack up
    } cpu_state_t;

endpackage

// File: logic/layer_prio.sv
/*
 * Layer priority for the colour mixer. Gates the four graphics layers,
 * merges sprite and tile per slot and picks the first opaque slot.
 */
`timescale 1ns/1ps

module layer_prio (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  colmix_pkg::gfx_en_t   gfx_en,
    input  colmix_pkg::char_pxl_t char_pxl,
    input  colmix_pkg::scr_pxl_t  scr1_pxl,
    input  colmix_pkg::scr_pxl_t  scr2_pxl,
    input  colmix_pkg::obj_pxl_t  obj_pxl,
    output colmix_pkg::pal_addr_t pal_addr,
    output logic                  shadow
);

    colmix_pkg::char_pxl_t char_g;
    colmix_pkg::scr_pxl_t  scr1_g;
    colmix_pkg::scr_pxl_t  scr2_g;
    colmix_pkg::obj_pxl_t  obj_g;
    logic [1:0]            obj_prio;

    colmix_pkg::lyr_t      lyr [4]; // slot 0 is the front
    colmix_pkg::lyr_t      win;

    // sprite over tile, or shadow over tile
    function automatic colmix_pkg::lyr_t tile_or_obj(
        input logic [9:0] obj,
        input logic [9:0] tile,
        input logic       tile_prio,
        input logic       oprio
    );
        logic take_obj;
        take_obj = (obj[3:0] != 4'd0) && oprio && (!tile_prio || tile[2:0] == 3'd0);
        if (!take_obj)
            tile_or_obj = {2'b00, tile};
        else if (&obj[9:4])
            tile_or_obj = {2'b10, tile}; // shadow sprite, tile shows through
        else
            tile_or_obj = {2'b01, obj};
    endfunction

    function automatic logic opaque(input colmix_pkg::lyr_t l);
        // tiles use colour 0 and 8 as transparent
        opaque = l[10] ? (l[3:0] != 4'd0) : (l[2:0] != 3'd0);
    endfunction

    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[colmix_pkg::GFX_CHAR]) char_g[3:0] = 4'd0;
        if (!gfx_en[colmix_pkg::GFX_SCR1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[colmix_pkg::GFX_SCR2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[colmix_pkg::GFX_OBJ])  obj_g[3:0]  = 4'd0;
    end

    assign obj_prio = obj_g[11:10];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                lyr[i] <= '0;
            end
        end else if (pxl_cen) begin
            lyr[0] <= tile_or_obj(obj_g[9:0], {4'd0, char_g[5:0]}, char_g[6],
                                  obj_prio == 2'd3);
            lyr[1] <= tile_or_obj(obj_g[9:0], scr1_g[9:0], scr1_g[10],
                                  obj_prio >= 2'd2);
            lyr[2] <= tile_or_obj(obj_g[9:0], scr2_g[9:0], scr2_g[10],
                                  obj_prio >= 2'd1);
            // backdrop slot, sprite always wins here
            lyr[3] <= tile_or_obj(obj_g[9:0], {scr2_g[9:4], 4'd0}, 1'b0, 1'b1);
        end
    end

    // first opaque slot wins, slot 3 as fallback
    always_comb begin
        win = lyr[3];
        for (int i = 2; i >= 0; i--) begin
            if (opaque(lyr[i])) win = lyr[i];
        end
    end

    assign {shadow, pal_addr} = win;

endmodule

// File: logic/palette_ram.sv
/*
 * Dual-port palette memory, 2K x 16. CPU side reads and writes with byte
 * enables over a four-phase req/ack handshake; video side reads each clk.
 */
`timescale 1ns/1ps

module palette_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req,
    input  logic                  cpu_we,
    input  colmix_pkg::pal_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t cpu_wdata,
    input  logic [1:0]            cpu_be,
    output colmix_pkg::pal_word_t cpu_rdata,
    output logic                  cpu_ack,
    input  colmix_pkg::pal_addr_t pal_addr,
    output colmix_pkg::pal_word_t pal_q
);

    colmix_pkg::pal_word_t  mem [colmix_pkg::PAL_WORDS];
    colmix_pkg::cpu_state_t state;
    logic                   access;
    logic                   wr_en;

    // palette comes up black
    initial begin
        for (int i = 0; i < colmix_pkg::PAL_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign access = (state == colmix_pkg::CPU_IDLE) && cpu_req; // one access per req
    assign wr_en  = access && cpu_we;

    // byte lanes
    always @(posedge clk) begin
        if (wr_en && cpu_be[0]) mem[cpu_addr][7:0]  <= cpu_wdata[7:0];
        if (wr_en && cpu_be[1]) mem[cpu_addr][15:8] <= cpu_wdata[15:8];
    end

    always_ff @(posedge clk) begin
        if (access && !cpu_we) begin
            cpu_rdata <= mem[cpu_addr]; // held until the next read
        end
    end

    // video port, one clk latency
    always_ff @(posedge clk) begin
        pal_q <= mem[pal_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= colmix_pkg::CPU_IDLE;
        end else begin
            case (state)
                colmix_pkg::CPU_IDLE: begin
                    if (cpu_req) state <= colmix_pkg::CPU_ACK;
                end
                colmix_pkg::CPU_ACK: begin
                    state <= cpu_req ? colmix_pkg::CPU_WAIT_LOW : colmix_pkg::CPU_IDLE;
                end
                colmix_pkg::CPU_WAIT_LOW: begin
                    // requester still holding req
                    if (!cpu_req) state <= colmix_pkg::CPU_IDLE;
                end
                default: begin
                    state <= colmix_pkg::CPU_IDLE;
                end
            endcase
        end
    end

    assign cpu_ack = (state != colmix_pkg::CPU_IDLE);

endmodule

// File: logic/shade_blank.sv
/*
 * Colour output stage. Unpacks the palette word, dims shadowed colours,
 * applies the video enable and keeps RGB aligned with delayed blanking.
 */
`timescale 1ns/1ps

module shade_blank (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  video_en,
    input  logic                  shadow,
    input  logic                  preLHBL,
    input  logic                  preLVBL,
    input  colmix_pkg::pal_word_t pal_q,
    output colmix_pkg::color_t    red,
    output colmix_pkg::color_t    green,
    output colmix_pkg::color_t    blue,
    output logic                  LHBL,
    output logic                  LVBL
);

    localparam int DLY = colmix_pkg::BLANK_DLY;

    logic [DLY-1:0]        hbl_dly;
    logic [DLY-1:0]        vbl_dly;
    logic [DLY-1:0]        ven_dly;
    colmix_pkg::pal_word_t pal_r;   // palette read stage
    logic                  shadow_r;
    colmix_pkg::color_t    rpal, gpal, bpal;
    colmix_pkg::rgb_t      gated;
    colmix_pkg::rgb_t      rgb_q;

    function automatic colmix_pkg::color_t dim(input colmix_pkg::color_t a);
        dim = a - (a >> 2); // roughly 3/4 brightness
    endfunction

    assign rpal = {pal_r[3:0],  pal_r[colmix_pkg::PAL_RLSB]};
    assign gpal = {pal_r[7:4],  pal_r[colmix_pkg::PAL_GLSB]};
    assign bpal = {pal_r[11:8], pal_r[colmix_pkg::PAL_BLSB]};

    always_comb begin
        if (shadow_r && !pal_r[colmix_pkg::PAL_NOSHD])
            gated = {dim(rpal), dim(gpal), dim(bpal)};
        else
            gated = {rpal, gpal, bpal};
        if (!ven_dly[DLY-1]) gated = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_dly  <= '0;
            vbl_dly  <= '0;
            ven_dly  <= '0;
            pal_r    <= '0;
            shadow_r <= 1'b0;
            rgb_q    <= '0;
            LHBL     <= 1'b0; // blanked
            LVBL     <= 1'b0;
        end else if (pxl_cen) begin
            hbl_dly  <= {hbl_dly[DLY-2:0], preLHBL};
            vbl_dly  <= {vbl_dly[DLY-2:0], preLVBL};
            ven_dly  <= {ven_dly[DLY-2:0], video_en};
            pal_r    <= pal_q;
            shadow_r <= shadow;
            LHBL     <= hbl_dly[DLY-1];
            LVBL     <= vbl_dly[DLY-1];
            // black during either blank
            rgb_q    <= (hbl_dly[DLY-1] && vbl_dly[DLY-1]) ? gated : '0;
        end
    end

    assign {red, green, blue} = rgb_q;

endmodule

// File: logic/video_mixer.sv
/*
 * Colour mixer top. Layer priority feeds the palette RAM, whose output
 * goes through shading and blanking to the RGB pins.
 */
`timescale 1ns/1ps

module video_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  video_en,
    input  colmix_pkg::gfx_en_t   gfx_en,
    input  logic                  preLHBL,
    input  logic                  preLVBL,
    input  colmix_pkg::char_pxl_t char_pxl,
    input  colmix_pkg::scr_pxl_t  scr1_pxl,
    input  colmix_pkg::scr_pxl_t  scr2_pxl,
    input  colmix_pkg::obj_pxl_t  obj_pxl,
    // CPU port
    input  logic                  cpu_req,
    input  logic                  cpu_we,
    input  colmix_pkg::pal_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t cpu_wdata,
    input  logic [1:0]            cpu_be,
    output colmix_pkg::pal_word_t cpu_rdata,
    output logic                  cpu_ack,
    // video out
    output colmix_pkg::color_t    red,
    output colmix_pkg::color_t    green,
    output colmix_pkg::color_t    blue,
    output logic                  LHBL,
    output logic                  LVBL
);

    colmix_pkg::pal_addr_t pal_addr;
    colmix_pkg::pal_word_t pal_q;
    logic                  shadow;

    layer_prio u_prio (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr),
        .shadow   (shadow)
    );

    palette_ram u_pal (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_be    (cpu_be),
        .cpu_rdata (cpu_rdata),
        .cpu_ack   (cpu_ack),
        .pal_addr  (pal_addr),
        .pal_q     (pal_q)
    );

    shade_blank u_shade (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .video_en (video_en),
        .shadow   (shadow),
        .preLHBL  (preLHBL),
        .preLVBL  (preLVBL),
        .pal_q    (pal_q),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .LHBL     (LHBL),
        .LVBL     (LVBL)
    );

endmodule

// File: sim/mixer_model.sv
/*
 * Reference model of the colour mixer: palette mirror fed from the CPU
 * port and a pixel path with a two-event output delay.
 */
`timescale 1ns/1ps

module mixer_model (
    input  logic        clk, rst, pxl_cen, video_en,
    input  logic [3:0]  gfx_en,
    input  logic        preLHBL, preLVBL,
    input  logic [6:0]  char_pxl,
    input  logic [10:0] scr1_pxl, scr2_pxl,
    input  logic [11:0] obj_pxl,
    input  logic        cpu_req, cpu_we, cpu_ack,
    input  logic [10:0] cpu_addr,
    input  logic [15:0] cpu_wdata,
    input  logic [1:0]  cpu_be,
    output logic [15:0] exp_rdata,
    output logic [14:0] exp_rgb,
    output logic        exp_lhbl,
    output logic        exp_lvbl
);

    logic [15:0] pal [colmix_pkg::PAL_WORDS];
    logic [16:0] pipe_q [$]; // {lhbl, lvbl, rgb}

    initial begin
        for (int i = 0; i < colmix_pkg::PAL_WORDS; i++) begin
            pal[i] <= 16'h0000;
        end
    end

    // request accepted while ack is low
    always @(posedge clk) begin
        if (!rst && cpu_req && !cpu_ack && cpu_we) begin
            if (cpu_be[0]) pal[cpu_addr][7:0] <= cpu_wdata[7:0];
            if (cpu_be[1]) pal[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
    end

    assign exp_rdata = pal[cpu_addr];

    // {shadow, sprite, index} for one slot
    function automatic logic [11:0] slot(input logic [9:0] tile, input logic tprio,
                                         input logic qual, input logic [9:0] obj);
        logic obj_wins;
        obj_wins = qual && (obj[3:0] != 4'd0) && (!tprio || tile[2:0] == 3'd0);
        if (obj_wins && obj[9:4] == 6'h3f) return {2'b10, tile};
        if (obj_wins) return {2'b01, obj};
        return {2'b00, tile};
    endfunction

    function automatic logic visible(input logic [11:0] c);
        return c[10] ? (c[3:0] != 4'd0) : (c[2:0] != 3'd0);
    endfunction

    function automatic logic [16:0] expect_pixel();
        logic [9:0]  ch, s1, s2, ob;
        logic [11:0] cand [4];
        logic [11:0] w;
        logic        found;
        logic [15:0] word;
        logic [4:0]  r, g, b;
        logic [14:0] rgb;
        ch = {4'd0, char_pxl[5:4], gfx_en[0] ? char_pxl[3:0] : 4'd0};
        s1 = {scr1_pxl[9:4], gfx_en[1] ? scr1_pxl[3:0] : 4'd0};
        s2 = {scr2_pxl[9:4], gfx_en[2] ? scr2_pxl[3:0] : 4'd0};
        ob = {obj_pxl[9:4], gfx_en[3] ? obj_pxl[3:0] : 4'd0};
        cand[0] = slot(ch, char_pxl[6], obj_pxl[11:10] == 2'd3, ob);
        cand[1] = slot(s1, scr1_pxl[10], obj_pxl[11:10] >= 2'd2, ob);
        cand[2] = slot(s2, scr2_pxl[10], obj_pxl[11:10] != 2'd0, ob);
        cand[3] = slot({s2[9:4], 4'd0}, 1'b0, 1'b1, ob); // backdrop
        w = cand[3];
        found = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!found && visible(cand[i])) begin
                w = cand[i];
                found = 1'b1;
            end
        end
        word = pal[w[10:0]];
        r = {word[3:0], word[12]};
        g = {word[7:4], word[13]};
        b = {word[11:8], word[14]};
        if (w[11] && !word[15]) begin
            r = r - (r >> 2);
            g = g - (g >> 2);
            b = b - (b >> 2);
        end
        rgb = {r, g, b};
        if (!video_en || !preLHBL || !preLVBL) rgb = 15'd0;
        return {preLHBL, preLVBL, rgb};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            pipe_q.delete();
            exp_rgb  <= 15'd0;
            exp_lhbl <= 1'b0;
            exp_lvbl <= 1'b0;
        end else if (pxl_cen) begin
            pipe_q.push_back(expect_pixel());
            if (pipe_q.size() > colmix_pkg::BLANK_DLY)
                {exp_lhbl, exp_lvbl, exp_rgb} <= pipe_q.pop_front();
        end
    end

endmodule

// File: sim/video_mixer_tb.sv
/*
 * Testbench for the colour mixer. Fills the palette over the CPU port,
 * streams LFSR pixels and compares every output with the reference model.
 */
`timescale 1ns/1ps

module video_mixer_tb;

    localparam int N_RW    = 128; // byte-lane writes, then as many reads
    localparam int N_CPU   = colmix_pkg::PAL_WORDS + 2 * N_RW;
    localparam int N_PRIO  = 800;
    localparam int N_SHD   = 300;
    localparam int N_EN    = 600;
    localparam int N_BLK   = 600;
    localparam int N_PIX   = N_PRIO + N_SHD + N_EN + N_BLK;
    localparam int TIMEOUT = (N_CPU * 8 + N_PIX * 2) * 2;

    localparam int MODE_PRIO   = 0;
    localparam int MODE_SHADOW = 1;
    localparam int MODE_ENABLE = 2;
    localparam int MODE_BLANK  = 3;

    logic                  clk, rst, pxl_cen, video_en;
    logic                  preLHBL, preLVBL;
    colmix_pkg::gfx_en_t   gfx_en;
    colmix_pkg::char_pxl_t char_pxl;
    colmix_pkg::scr_pxl_t  scr1_pxl, scr2_pxl;
    colmix_pkg::obj_pxl_t  obj_pxl;
    logic                  cpu_req, cpu_we, cpu_ack;
    colmix_pkg::pal_addr_t cpu_addr;
    colmix_pkg::pal_word_t cpu_wdata, cpu_rdata, exp_rdata;
    logic [1:0]            cpu_be;
    colmix_pkg::color_t    red, green, blue;
    logic                  LHBL, LVBL, exp_lhbl, exp_lvbl;
    colmix_pkg::rgb_t      exp_rgb;
    logic [31:0]           lfsr;
    int                    cycles = 0;
    colmix_pkg::pal_addr_t wr_q [$];

    video_mixer dut (.*);
    mixer_model ref_model (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #1;
        pxl_cen = ~pxl_cen; // one pixel every second clk
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run did not finish within %0d clock cycles", TIMEOUT);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "mismatch");
        end
    endtask

    // outputs settle at the rising edge and are sampled half a clock later
    always @(negedge clk) begin
        if (!rst) begin
            check_eq(32'({red, green, blue}), 32'(exp_rgb), "rgb");
            check_eq(32'(LHBL), 32'(exp_lhbl), "LHBL");
            check_eq(32'(LVBL), 32'(exp_lvbl), "LVBL");
            if (!LHBL || !LVBL) check_eq(32'({red, green, blue}), 32'd0, "rgb while blanked");
        end
    end

    // starts and ends 1 ns after a rising edge with ack low
    task automatic cpu_access(input logic we, input colmix_pkg::pal_addr_t addr,
                              input colmix_pkg::pal_word_t data, input logic [1:0] be);
        int          cnt;
        logic [31:0] r;
        r = rnd(2);
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_be    = be;
        cnt = 0;
        while (!cpu_ack) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        check_eq(cnt, 1, "req to ack latency");
        if (!we) check_eq(32'(cpu_rdata), 32'(exp_rdata), "cpu read data");
        repeat (r[1:0]) begin // requester stalls
            @(posedge clk);
            #1;
            check_eq(32'(cpu_ack), 32'd1, "ack held while req high");
        end
        cpu_req = 1'b0;
        cnt = 0;
        while (cpu_ack) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        check_eq(cnt, 1, "req drop to ack drop");
    endtask

    task automatic next_event();
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);
        #1;
    endtask

    task automatic drive_pixels(input int count, input int mode);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            next_event();
            r = rnd(7);
            char_pxl = r[6:0];
            r = rnd(11);
            scr1_pxl = r[10:0];
            r = rnd(11);
            scr2_pxl = r[10:0];
            r = rnd(12);
            obj_pxl  = r[11:0];
            gfx_en   = 4'hf;
            video_en = 1'b1;
            preLHBL  = 1'b1;
            preLVBL  = 1'b1;
            if (mode == MODE_SHADOW) begin
                r = rnd(3);
                obj_pxl[9:0] = {6'h3f, r[2:0], 1'b1}; // opaque shadow sprite
            end else if (mode == MODE_ENABLE) begin
                r = rnd(6);
                gfx_en   = r[3:0];
                video_en = (r[5:4] != 2'b00);
            end else if (mode == MODE_BLANK) begin
                r = rnd(4);
                preLHBL = (r[1:0] != 2'b00);
                preLVBL = (r[3:2] != 2'b00);
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        rst = 1'b1;
        pxl_cen = 1'b0;
        video_en = 1'b0;
        gfx_en = '0;
        preLHBL = 1'b0;
        preLVBL = 1'b0;
        char_pxl = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        obj_pxl = '0;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_be = '0;
        lfsr = 32'ha89a;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_eq(32'(cpu_ack), 32'd0, "cpu_ack after reset");
        check_eq(32'({red, green, blue}), 32'd0, "rgb after reset");
        check_eq(32'({LHBL, LVBL}), 32'd0, "blanking after reset");
        @(posedge clk);
        #1;

        // whole palette first then partial writes that are read back
        for (int a = 0; a < colmix_pkg::PAL_WORDS; a++) begin
            r = rnd(16);
            cpu_access(1'b1, a[10:0], r[15:0], 2'b11);
        end
        for (int i = 0; i < N_RW; i++) begin
            r = rnd(29);
            cpu_access(1'b1, r[10:0], r[26:11], r[28:27]);
            wr_q.push_back(r[10:0]);
        end
        foreach (wr_q[i]) cpu_access(1'b0, wr_q[i], 16'h0000, 2'b00);
        $display("cpu port phase done, %0d transactions", N_CPU);

        drive_pixels(N_PRIO, MODE_PRIO);
        drive_pixels(N_SHD, MODE_SHADOW);
        drive_pixels(N_EN, MODE_ENABLE);
        drive_pixels(N_BLK, MODE_BLANK);
        repeat (4) next_event(); // last pixel reaches the outputs and gets compared
        $display("pixel phases done, %0d pixels", N_PIX);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: video_mixer.f
logic/colmix_pkg.sv
logic/layer_prio.sv
logic/palette_ram.sv
logic/shade_blank.sv
logic/video_mixer.sv
sim/mixer_model.sv
sim/video_mixer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the colour mixer testbench with Verilator.
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module video_mixer_tb \
    -f video_mixer.f --Mdir "$BUILD_DIR" -o video_mixer_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/video_mixer_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q 'All tests passed!' "$LOG"; then
    echo "RESULT: PASS"
    exit 0
fi
echo "RESULT: FAIL"
exit 1
